// File: compile.f
source/muldiv_pkg.sv
source/mul_partial.sv
source/div_radix2.sv
source/muldiv_result.sv
source/muldiv_ctrl.sv
source/muldiv_unit.sv
verification/tb_clock.sv
verification/muldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the multiply/divide unit testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module muldiv_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmuldiv_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: source/div_radix2.sv
// Restoring radix-2 divider, one quotient bit per cycle.
// start_i loads the operands; 32 iteration cycles follow, then one
// sign-fix cycle that pulses done_o. res_o is {remainder, quotient}
// and holds until the next start.

`timescale 1ns/100ps

module div_radix2 (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           start_i,
    input  logic                           signed_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  dividend_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  divisor_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [muldiv_pkg::DWORD_W-1:0] res_o
);
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(WORD_W) + 1;
    localparam logic [CNT_W-1:0] ITER_DONE = CNT_W'(WORD_W);

    logic [WORD_W-1:0] rem_q;
    logic [WORD_W-1:0] quo_q;
    logic [WORD_W-1:0] dsr_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              neg_quo;
    logic              neg_rem;
    logic              div_zero;

    logic [WORD_W-1:0] dvd_mag;
    logic [WORD_W-1:0] dsr_mag;
    logic [WORD_W:0]   shifted;
    logic [WORD_W:0]   diff;
    logic              fits;
    logic [WORD_W-1:0] rem_fix;
    logic [WORD_W-1:0] quo_fix;

    assign dvd_mag = (signed_i && dividend_i[WORD_W-1]) ? -dividend_i : dividend_i;
    assign dsr_mag = (signed_i && divisor_i[WORD_W-1]) ? -divisor_i : divisor_i;

    // bring down the next dividend bit and try the subtraction.
    assign shifted = {rem_q, quo_q[WORD_W-1]};
    assign diff    = shifted - {1'b0, dsr_q};
    assign fits    = shifted >= {1'b0, dsr_q};

    // a zero divisor leaves all ones in the quotient and the dividend
    // magnitude in the remainder, so only the remainder sign is restored.
    assign rem_fix = neg_rem ? -rem_q : rem_q;
    assign quo_fix = (neg_quo && !div_zero) ? -quo_q : quo_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_o <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_o) begin
                if (cnt_q == ITER_DONE) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q    <= '0;
            quo_q    <= dvd_mag;
            dsr_q    <= dsr_mag;
            neg_quo  <= signed_i && (dividend_i[WORD_W-1] ^ divisor_i[WORD_W-1]);
            neg_rem  <= signed_i && dividend_i[WORD_W-1];
            div_zero <= (divisor_i == '0);
        end else if (busy_o) begin
            if (cnt_q == ITER_DONE) begin
                res_o <= {rem_fix, quo_fix};
            end else begin
                rem_q <= fits ? diff[WORD_W-1:0] : shifted[WORD_W-1:0];
                quo_q <= {quo_q[WORD_W-2:0], fits};
            end
        end
    end

endmodule

// File: source/mul_partial.sv
// Partial-product multiplier front end.
// On start it takes the operand magnitudes and registers four 16x16
// products plus the result sign; the result stage sums and signs them.
// Outputs hold until the next start.

`timescale 1ns/100ps

module mul_partial (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           start_i,
    input  logic                           signed_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  a_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  b_i,
    output logic [muldiv_pkg::DWORD_W-1:0] mulhi_o,
    output logic [muldiv_pkg::DWORD_W-1:0] mullo_o,
    output logic                           mul_s_o
);
    import muldiv_pkg::*;

    localparam int HALF_W = WORD_W / 2;

    logic [WORD_W-1:0] a_mag;
    logic [WORD_W-1:0] b_mag;
    logic [WORD_W-1:0] p_ll;
    logic [WORD_W-1:0] p_lh;
    logic [WORD_W-1:0] p_hl;
    logic [WORD_W-1:0] p_hh;

    assign a_mag = (signed_i && a_i[WORD_W-1]) ? -a_i : a_i;
    assign b_mag = (signed_i && b_i[WORD_W-1]) ? -b_i : b_i;

    // operands are widened to 32 bits by the assignment context.
    assign p_ll = a_mag[HALF_W-1:0] * b_mag[HALF_W-1:0];
    assign p_lh = a_mag[HALF_W-1:0] * b_mag[WORD_W-1:HALF_W];
    assign p_hl = a_mag[WORD_W-1:HALF_W] * b_mag[HALF_W-1:0];
    assign p_hh = a_mag[WORD_W-1:HALF_W] * b_mag[WORD_W-1:HALF_W];

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            mullo_o <= {p_lh, p_ll};
            mulhi_o <= {p_hh, p_hl};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mul_s_o <= 1'b0;
        end else if (start_i) begin
            mul_s_o <= signed_i && (a_i[WORD_W-1] ^ b_i[WORD_W-1]);
        end
    end

endmodule

// File: source/muldiv_ctrl.sv
// Sequencer for the multiply/divide unit and owner of HI/LO.
// Accepts one op in IDLE, starts the proper engine, waits for it and
// writes HI/LO in FINISH together with a registered done pulse.
// Non-divide ops see done_o in the third cycle after op_valid_i.

`timescale 1ns/100ps

module muldiv_ctrl (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           op_valid_i,
    input  muldiv_pkg::muldiv_op_e         op_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  rs_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  rt_i,
    input  logic                           div_done_i,
    input  logic                           whilo_i,
    input  logic [muldiv_pkg::DWORD_W-1:0] hilo_new_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  res_word_i,
    output logic                           mul_start_o,
    output logic                           div_start_o,
    output logic                           div_signed_o,
    output logic [muldiv_pkg::WORD_W-1:0]  op_a_o,
    output logic [muldiv_pkg::WORD_W-1:0]  op_b_o,
    output muldiv_pkg::muldiv_op_e         op_q_o,
    output logic [muldiv_pkg::WORD_W-1:0]  rs_q_o,
    output logic [muldiv_pkg::DWORD_W-1:0] hilo_o,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [muldiv_pkg::WORD_W-1:0]  result_o
);
    import muldiv_pkg::*;

    ctrl_state_e       state_q;
    logic [WORD_W-1:0] rs_q;
    logic [WORD_W-1:0] rt_q;
    logic              accept;
    logic              is_mul;
    logic              is_div;
    logic              is_signed;

    assign accept    = (state_q == IDLE) && op_valid_i;
    assign is_mul    = op_i inside {MULT, MULTU, MUL, MADD, MADDU, MSUB, MSUBU};
    assign is_div    = op_i inside {DIV, DIVU};
    // one flag serves both engines.
    assign is_signed = op_i inside {MULT, MUL, MADD, MSUB, DIV};

    assign busy_o = (state_q != IDLE);
    assign op_a_o = rs_q;
    assign op_b_o = rt_q;
    assign rs_q_o = rs_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= IDLE;
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            done_o      <= 1'b0;
            hilo_o      <= '0;
        end else begin
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            done_o      <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (op_valid_i) begin
                        mul_start_o <= is_mul;
                        div_start_o <= is_div;
                        state_q     <= is_div ? DIV_WAIT : MUL_WAIT;
                    end
                end
                // partials are registered at the end of this cycle.
                MUL_WAIT: begin
                    state_q <= FINISH;
                end
                DIV_WAIT: begin
                    if (div_done_i) begin
                        state_q <= FINISH;
                    end
                end
                FINISH: begin
                    if (whilo_i) begin
                        hilo_o <= hilo_new_i;
                    end
                    done_o  <= 1'b1;
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q_o       <= op_i;
            rs_q         <= rs_i;
            rt_q         <= rt_i;
            div_signed_o <= is_signed;
        end
        if (state_q == FINISH) begin
            result_o <= res_word_i;
        end
    end

endmodule

// File: source/muldiv_pkg.sv
// Shared types and widths for the multiply/divide unit.
// Modules refer to the widths by scoped name in their port lists
// and import the package in the body for everything else.

package muldiv_pkg;

    localparam int WORD_W  = 32;
    localparam int DWORD_W = 64;

    // one code per supported instruction.
    typedef enum logic [3:0] {
        MULT  = 4'h0,
        MULTU = 4'h1,
        MUL   = 4'h2,
        MADD  = 4'h3,
        MADDU = 4'h4,
        MSUB  = 4'h5,
        MSUBU = 4'h6,
        DIV   = 4'h7,
        DIVU  = 4'h8,
        MFHI  = 4'h9,
        MFLO  = 4'ha,
        MTHI  = 4'hb,
        MTLO  = 4'hc
    } muldiv_op_e;

    // controller sequencing.
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        MUL_WAIT = 2'd1,
        DIV_WAIT = 2'd2,
        FINISH   = 2'd3
    } ctrl_state_e;

endpackage

// File: source/muldiv_result.sv
// HI/LO result stage, purely combinational.
// Rebuilds the 64-bit product from the registered partials and picks
// the new HI/LO, its write enable and the 32-bit result per opcode.
// Opcodes outside the table pass rs_i through as the result.

`timescale 1ns/100ps

module muldiv_result (
    input  muldiv_pkg::muldiv_op_e         op_i,
    input  logic [muldiv_pkg::WORD_W-1:0]  rs_i,
    input  logic [muldiv_pkg::DWORD_W-1:0] mulhi_i,
    input  logic [muldiv_pkg::DWORD_W-1:0] mullo_i,
    input  logic                           mul_s_i,
    input  logic [muldiv_pkg::DWORD_W-1:0] div_res_i,
    input  logic [muldiv_pkg::DWORD_W-1:0] hilo_i,
    output logic                           whilo_o,
    output logic [muldiv_pkg::DWORD_W-1:0] hilo_o,
    output logic [muldiv_pkg::WORD_W-1:0]  res_o
);
    import muldiv_pkg::*;

    localparam int HALF_W = WORD_W / 2;
    localparam int PART_W = WORD_W + HALF_W;

    logic [PART_W-1:0]  res_lo;
    logic [PART_W-1:0]  res_hi;
    logic [DWORD_W-1:0] umres;
    logic [DWORD_W-1:0] smres;
    logic [WORD_W-1:0]  hi_cur;
    logic [WORD_W-1:0]  lo_cur;

    // al*bl + (al*bh << 16) and ah*bl + (ah*bh << 16).
    assign res_lo = {{HALF_W{1'b0}}, mullo_i[WORD_W-1:0]}
                  + {mullo_i[DWORD_W-1:WORD_W], {HALF_W{1'b0}}};
    assign res_hi = {{HALF_W{1'b0}}, mulhi_i[WORD_W-1:0]}
                  + {mulhi_i[DWORD_W-1:WORD_W], {HALF_W{1'b0}}};
    assign umres  = {{HALF_W{1'b0}}, res_lo} + {res_hi, {HALF_W{1'b0}}};
    assign smres  = mul_s_i ? -umres : umres;

    assign hi_cur = hilo_i[DWORD_W-1:WORD_W];
    assign lo_cur = hilo_i[WORD_W-1:0];

    always_comb begin
        whilo_o = 1'b1;
        hilo_o  = hilo_i;
        res_o   = '0;
        case (op_i)
            MFHI: begin
                whilo_o = 1'b0;
                res_o   = hi_cur;
            end
            MFLO: begin
                whilo_o = 1'b0;
                res_o   = lo_cur;
            end
            MTHI: begin
                hilo_o = {rs_i, lo_cur};
            end
            MTLO: begin
                hilo_o = {hi_cur, rs_i};
            end
            MULT: begin
                hilo_o = smres;
            end
            MULTU: begin
                hilo_o = umres;
            end
            MUL: begin
                // low word goes to the result and HI/LO stays as it is.
                whilo_o = 1'b0;
                res_o   = smres[WORD_W-1:0];
            end
            MADD: begin
                hilo_o = hilo_i + smres;
            end
            MADDU: begin
                hilo_o = hilo_i + umres;
            end
            MSUB: begin
                hilo_o = hilo_i - smres;
            end
            MSUBU: begin
                hilo_o = hilo_i - umres;
            end
            DIV, DIVU: begin
                hilo_o = div_res_i;
            end
            default: begin
                whilo_o = 1'b0;
                res_o   = rs_i;
            end
        endcase
    end

endmodule

// File: source/muldiv_unit.sv
// Top level of the multiply/divide unit.
// Issue one op with op_valid_i; ops arriving while busy_o is high are
// dropped. result_o is valid with the done_o pulse, and hi_o/lo_o
// always show the HI/LO pair.

`timescale 1ns/100ps

module muldiv_unit (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          op_valid_i,
    input  muldiv_pkg::muldiv_op_e        op_i,
    input  logic [muldiv_pkg::WORD_W-1:0] rs_i,
    input  logic [muldiv_pkg::WORD_W-1:0] rt_i,
    output logic                          busy_o,
    output logic                          done_o,
    output logic [muldiv_pkg::WORD_W-1:0] result_o,
    output logic [muldiv_pkg::WORD_W-1:0] hi_o,
    output logic [muldiv_pkg::WORD_W-1:0] lo_o
);
    import muldiv_pkg::*;

    logic               mul_start;
    logic               div_start;
    logic               div_signed;
    logic [WORD_W-1:0]  op_a;
    logic [WORD_W-1:0]  op_b;
    muldiv_op_e         op_q;
    logic [WORD_W-1:0]  rs_q;
    logic [DWORD_W-1:0] hilo;
    logic [DWORD_W-1:0] mulhi;
    logic [DWORD_W-1:0] mullo;
    logic               mul_s;
    logic               div_done;
    logic [DWORD_W-1:0] div_res;
    logic               whilo;
    logic [DWORD_W-1:0] hilo_new;
    logic [WORD_W-1:0]  res_word;

    assign hi_o = hilo[DWORD_W-1:WORD_W];
    assign lo_o = hilo[WORD_W-1:0];

    muldiv_ctrl muldiv_ctrl_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .rs_i         (rs_i),
        .rt_i         (rt_i),
        .div_done_i   (div_done),
        .whilo_i      (whilo),
        .hilo_new_i   (hilo_new),
        .res_word_i   (res_word),
        .mul_start_o  (mul_start),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .op_q_o       (op_q),
        .rs_q_o       (rs_q),
        .hilo_o       (hilo),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .result_o     (result_o)
    );

    mul_partial mul_partial_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .start_i  (mul_start),
        .signed_i (div_signed),
        .a_i      (op_a),
        .b_i      (op_b),
        .mulhi_o  (mulhi),
        .mullo_o  (mullo),
        .mul_s_o  (mul_s)
    );

    // the controller tracks the divide through div_done alone.
    div_radix2 div_radix2_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (op_a),
        .divisor_i  (op_b),
        .busy_o     (),
        .done_o     (div_done),
        .res_o      (div_res)
    );

    muldiv_result muldiv_result_i (
        .op_i      (op_q),
        .rs_i      (rs_q),
        .mulhi_i   (mulhi),
        .mullo_i   (mullo),
        .mul_s_i   (mul_s),
        .div_res_i (div_res),
        .hilo_i    (hilo),
        .whilo_o   (whilo),
        .hilo_o    (hilo_new),
        .res_o     (res_word)
    );

endmodule

// File: verification/muldiv_tb.sv
// Testbench for the multiply/divide unit.
// Runs a reset check, a table of directed ops with literal expected values,
// a dropped-op test during a divide and a section of LFSR-random ops.
// Inputs change on the falling clock edge; outputs are sampled there too.

`timescale 1ns/100ps

module muldiv_tb;
    import muldiv_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int OP_CYCLES    = 40;
    localparam int N_TABLE      = 29;
    localparam int N_RAND       = 24;
    localparam int N_OPS        = N_TABLE + N_RAND + 2;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + OP_CYCLES * N_OPS;

    typedef struct packed {
        muldiv_op_e  op;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] res;
        logic [31:0] hi;
        logic [31:0] lo;
    } vec_t;

    logic        clk;
    logic        reset;
    logic        op_valid;
    muldiv_op_e  op;
    logic [31:0] rs;
    logic [31:0] rt;
    logic        busy;
    logic        done;
    logic [31:0] result;
    logic [31:0] hi;
    logic [31:0] lo;

    vec_t        table_q[$];
    vec_t        vec;
    int          errors;
    int          tests;
    int          passed;
    int          cycle_count = 0;
    logic [31:0] lfsr_q;
    logic [63:0] exp_hilo;
    logic [63:0] new_hilo;
    logic [31:0] exp_res;
    logic [31:0] sel;
    logic [31:0] rs_r;
    logic [31:0] rt_r;
    muldiv_op_e  op_r;
    muldiv_op_e  rand_ops [8] = '{MULT, MULTU, MUL, MADD, MSUB, MSUBU, DIV, DIVU};

    tb_clock #(.PERIOD_NS(8)) tb_clock_i (.clk_o(clk));

    muldiv_unit muldiv_unit_i (
        .clk_i      (clk),
        .reset_i    (reset),
        .op_valid_i (op_valid),
        .op_i       (op),
        .rs_i       (rs),
        .rt_i       (rt),
        .busy_o     (busy),
        .done_o     (done),
        .result_o   (result),
        .hi_o       (hi),
        .lo_o       (lo)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            $display("%s: mismatch", name);
        end
    endtask

    // galois form with taps at 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic logic [63:0] mul_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic sgn);
        logic [63:0] wa;
        logic [63:0] wb;
        wa = sgn ? {{32{a[31]}}, a} : {32'h0, a};
        wb = sgn ? {{32{b[31]}}, b} : {32'h0, b};
        return wa * wb;
    endfunction

    // returns {remainder, quotient} with the quotient truncated toward zero.
    function automatic logic [63:0] div_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic sgn);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        if (b == 32'h0) begin
            return {a, 32'hffffffff};
        end
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        q  = ma / mb;
        r  = ma % mb;
        if (sgn && (a[31] ^ b[31])) begin
            q = -q;
        end
        if (sgn && a[31]) begin
            r = -r;
        end
        return {r, q};
    endfunction

    task automatic model_op(input muldiv_op_e op_v, input logic [31:0] rs_v,
                            input logic [31:0] rt_v, input logic [63:0] hilo_in,
                            output logic [63:0] hilo_out, output logic [31:0] res_v);
        logic [63:0] prod;
        logic [63:0] uprod;
        prod     = mul_model(rs_v, rt_v, 1'b1);
        uprod    = mul_model(rs_v, rt_v, 1'b0);
        hilo_out = hilo_in;
        res_v    = '0;
        case (op_v)
            MULT:    hilo_out = prod;
            MULTU:   hilo_out = uprod;
            MUL:     res_v = prod[31:0];
            MADD:    hilo_out = hilo_in + prod;
            MADDU:   hilo_out = hilo_in + uprod;
            MSUB:    hilo_out = hilo_in - prod;
            MSUBU:   hilo_out = hilo_in - uprod;
            DIV:     hilo_out = div_model(rs_v, rt_v, 1'b1);
            DIVU:    hilo_out = div_model(rs_v, rt_v, 1'b0);
            MFHI:    res_v = hilo_in[63:32];
            MFLO:    res_v = hilo_in[31:0];
            MTHI:    hilo_out = {rs_v, hilo_in[31:0]};
            MTLO:    hilo_out = {hilo_in[63:32], rs_v};
            default: res_v = rs_v;
        endcase
    endtask

    task automatic issue_op(input muldiv_op_e op_v, input logic [31:0] rs_v,
                            input logic [31:0] rt_v, output logic got, output int lat);
        got = 1'b0;
        lat = 0;
        @(negedge clk);
        op_valid = 1'b1;
        op       = op_v;
        rs       = rs_v;
        rt       = rt_v;
        while (!got && lat < OP_CYCLES) begin
            @(negedge clk);
            op_valid = 1'b0;
            lat++;
            got = done;
        end
    endtask

    task automatic run_and_check(input string label, input int idx, input muldiv_op_e op_v,
                                 input logic [31:0] rs_v, input logic [31:0] rt_v,
                                 input logic [31:0] e_res, input logic [31:0] e_hi,
                                 input logic [31:0] e_lo);
        logic got;
        int   lat;
        int   errs_before;
        errs_before = errors;
        issue_op(op_v, rs_v, rt_v, got, lat);
        if (!got) begin
            $display("%s %0d: no done_o within %0d cycles", label, idx, OP_CYCLES);
            errors++;
        end else begin
            check_value("result_o", result, e_res);
            check_value("hi_o", hi, e_hi);
            check_value("lo_o", lo, e_lo);
            // every op other than a divide has a fixed latency.
            if (op_v != DIV && op_v != DIVU) begin
                check_value("latency", lat, 3);
            end
        end
        report_test($sformatf("%s %0d %s rs=%h rt=%h", label, idx, op_v.name(), rs_v, rt_v),
                    errs_before);
    endtask

    task automatic add_vec(input muldiv_op_e op_v, input logic [31:0] rs_v,
                           input logic [31:0] rt_v, input logic [31:0] res_v,
                           input logic [31:0] hi_v, input logic [31:0] lo_v);
        vec_t v;
        v.op  = op_v;
        v.rs  = rs_v;
        v.rt  = rt_v;
        v.res = res_v;
        v.hi  = hi_v;
        v.lo  = lo_v;
        table_q.push_back(v);
    endtask

    // hi/lo columns carry over from one row to the next.
    task automatic build_table();
        add_vec(MTHI,  32'h12345678, 32'h00000000, 32'h00000000, 32'h12345678, 32'h00000000);
        add_vec(MTLO,  32'h9abcdef0, 32'h00000000, 32'h00000000, 32'h12345678, 32'h9abcdef0);
        add_vec(MFHI,  32'h00000000, 32'h00000000, 32'h12345678, 32'h12345678, 32'h9abcdef0);
        add_vec(MFLO,  32'h00000000, 32'h00000000, 32'h9abcdef0, 32'h12345678, 32'h9abcdef0);
        add_vec(MULT,  32'hfffffffd, 32'hfffffff9, 32'h00000000, 32'h00000000, 32'h00000015);
        add_vec(MULT,  32'h80000000, 32'h80000000, 32'h00000000, 32'h40000000, 32'h00000000);
        add_vec(MULT,  32'h80000000, 32'h00000001, 32'h00000000, 32'hffffffff, 32'h80000000);
        add_vec(MULT,  32'h7fffffff, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000);
        add_vec(MULTU, 32'hffffffff, 32'hffffffff, 32'h00000000, 32'hfffffffe, 32'h00000001);
        add_vec(MULTU, 32'h80000000, 32'h00000002, 32'h00000000, 32'h00000001, 32'h00000000);
        add_vec(MUL,   32'hfffffffe, 32'h00000003, 32'hfffffffa, 32'h00000001, 32'h00000000);
        add_vec(MUL,   32'h00010000, 32'h00010000, 32'h00000000, 32'h00000001, 32'h00000000);
        add_vec(MTHI,  32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000);
        add_vec(MTLO,  32'h00000010, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000010);
        add_vec(MADD,  32'h00000003, 32'h00000005, 32'h00000000, 32'h00000000, 32'h0000001f);
        add_vec(MADD,  32'hffffffff, 32'h00000020, 32'h00000000, 32'hffffffff, 32'hffffffff);
        add_vec(MADDU, 32'hffffffff, 32'h00000002, 32'h00000000, 32'h00000001, 32'hfffffffd);
        add_vec(MSUB,  32'hfffffffe, 32'h00000004, 32'h00000000, 32'h00000002, 32'h00000005);
        add_vec(MSUBU, 32'h00000003, 32'h00000001, 32'h00000000, 32'h00000002, 32'h00000002);
        add_vec(MSUBU, 32'hffffffff, 32'h00000001, 32'h00000000, 32'h00000001, 32'h00000003);
        add_vec(DIV,   32'hfffffff9, 32'h00000002, 32'h00000000, 32'hffffffff, 32'hfffffffd);
        add_vec(DIV,   32'h00000007, 32'hfffffffe, 32'h00000000, 32'h00000001, 32'hfffffffd);
        add_vec(DIV,   32'hfffffff9, 32'hfffffffe, 32'h00000000, 32'hffffffff, 32'h00000003);
        add_vec(DIVU,  32'hfffffff9, 32'h00000002, 32'h00000000, 32'h00000001, 32'h7ffffffc);
        add_vec(DIV,   32'h80000000, 32'hffffffff, 32'h00000000, 32'h00000000, 32'h80000000);
        add_vec(DIV,   32'h00000064, 32'h00000000, 32'h00000000, 32'h00000064, 32'hffffffff);
        add_vec(DIV,   32'hfffffff0, 32'h00000000, 32'h00000000, 32'hfffffff0, 32'hffffffff);
        add_vec(DIVU,  32'h12345678, 32'h00000000, 32'h00000000, 32'h12345678, 32'hffffffff);
        add_vec(MFHI,  32'h00000000, 32'h00000000, 32'h12345678, 32'h12345678, 32'hffffffff);
    endtask

    // a second op arriving mid-divide must be dropped.
    task automatic busy_drop_test();
        int done_count;
        int cycles;
        int errs_before;
        errs_before = errors;
        done_count  = 0;
        cycles      = 0;
        @(negedge clk);
        op_valid = 1'b1;
        op       = DIV;
        rs       = 32'd100;
        rt       = 32'd7;
        @(negedge clk);
        op_valid = 1'b0;
        repeat (3) @(negedge clk);
        check_value("busy_o", busy, 1'b1);
        op_valid = 1'b1;
        op       = MTHI;
        rs       = 32'hdeadbeef;
        @(negedge clk);
        op_valid = 1'b0;
        while (cycles < OP_CYCLES + 10) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                done_count++;
                check_value("result_o", result, 32'h0);
            end
        end
        check_value("done_o count", done_count, 1);
        check_value("hi_o", hi, 32'h2);
        check_value("lo_o", lo, 32'he);
        exp_hilo = {32'h2, 32'he};
        report_test("busy drop", errs_before);
    endtask

    initial begin
        reset    = 1'b1;
        op_valid = 1'b0;
        op       = MFHI;
        rs       = '0;
        rt       = '0;
        errors   = 0;
        tests    = 0;
        passed   = 0;
        lfsr_q   = 32'hba17;
        exp_hilo = '0;
        build_table();
        if (table_q.size() != N_TABLE) begin
            $display("table holds %0d rows instead of %0d", table_q.size(), N_TABLE);
            errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_value("hi_o", hi, 32'h0);
        check_value("lo_o", lo, 32'h0);
        check_value("busy_o", busy, 1'b0);
        check_value("done_o", done, 1'b0);
        report_test("reset", 0);

        for (int i = 0; i < table_q.size(); i++) begin
            vec = table_q[i];
            run_and_check("table", i, vec.op, vec.rs, vec.rt, vec.res, vec.hi, vec.lo);
            exp_hilo = {vec.hi, vec.lo};
        end

        busy_drop_test();

        for (int i = 0; i < N_RAND; i++) begin
            take_bits(3, sel);
            op_r = rand_ops[sel[2:0]];
            take_bits(32, rs_r);
            take_bits(32, rt_r);
            // now and then use a small signed divisor that may be zero.
            take_bits(1, sel);
            if (sel[0]) begin
                take_bits(4, sel);
                rt_r = {{28{sel[3]}}, sel[3:0]};
            end
            model_op(op_r, rs_r, rt_r, exp_hilo, new_hilo, exp_res);
            run_and_check("random", i, op_r, rs_r, rt_r, exp_res,
                          new_hilo[63:32], new_hilo[31:0]);
            exp_hilo = new_hilo;
        end

        $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock.sv
// Free-running clock for the testbench.
// The period is set by the instantiating module.

`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule
